// File: div_data_pkg.sv
// data widths and word types for the division unit
// shared by the RTL and the testbench

`default_nettype none

package div_data_pkg;

  // operand width of the unit unless the top level overrides it
  localparam int DIV_WIDTH = 16;

  // one operand or result word
  typedef logic [DIV_WIDTH-1:0] word_t;

  // double-width signed word, room for sign handling without overflow
  typedef logic signed [2*DIV_WIDTH-1:0] wide_t;

endpackage

`default_nettype wire

// File: div_ctrl_pkg.sv
// control state types of the iterative divider core

`default_nettype none

package div_ctrl_pkg;

  // core sequencing
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // waiting for start
    ST_RUN  = 2'd1,  // one quotient bit per cycle
    ST_DONE = 2'd2   // result register edge
  } core_state_t;

endpackage

`default_nettype wire

// File: div_core_if.sv
// request/result bundle between the divider blocks
// src drives, dst consumes, mon only observes

`timescale 1ns/1ps
`default_nettype none

interface div_core_if #(
  parameter int WIDTH = div_data_pkg::DIV_WIDTH
);

  // request side
  logic             start;
  logic [WIDTH-1:0] dividend_mag;
  logic [WIDTH-1:0] divisor_mag;
  logic             neg_quot;      // quotient gets negated
  logic             neg_rem;       // remainder gets negated
  logic             zero_div;      // divisor was zero

  // result side
  logic             done;
  logic [WIDTH-1:0] quot_mag;
  logic [WIDTH-1:0] rem_mag;

  modport src (output start, dividend_mag, divisor_mag, neg_quot, neg_rem, zero_div,
               output done, quot_mag, rem_mag);

  modport dst (input start, dividend_mag, divisor_mag, neg_quot, neg_rem, zero_div,
               input done, quot_mag, rem_mag);

  modport mon (input start, dividend_mag, divisor_mag, neg_quot, neg_rem, zero_div,
               input done, quot_mag, rem_mag);

endinterface

`default_nettype wire

// File: div_operand_prep.sv
// request acceptance and busy tracking
// converts signed operands to magnitudes and records the result signs

`timescale 1ns/1ps
`default_nettype none

module div_operand_prep #(
  parameter int WIDTH = div_data_pkg::DIV_WIDTH
)
(
  input  logic             CLK,
  input  logic             CLR,
  input  logic             in_valid,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic             busy,
  div_core_if.src          req,
  div_core_if.mon          res
);

  logic             accept;
  logic             a_neg;
  logic             b_neg;
  logic             b_zero;
  logic [WIDTH-1:0] a_abs;
  logic [WIDTH-1:0] b_abs;

  assign accept = in_valid && !busy;  // requests while busy are dropped

  assign a_neg  = is_signed && dividend[WIDTH-1];
  assign b_neg  = is_signed && divisor[WIDTH-1];
  assign b_zero = (divisor == '0);

  // most negative value maps onto itself, which is its unsigned magnitude
  assign a_abs = a_neg ? (~dividend + 1'b1) : dividend;
  assign b_abs = b_neg ? (~divisor + 1'b1) : divisor;

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
      busy <= 1'b0;
    else if (accept)
      busy <= 1'b1;
    else if (res.done)
      busy <= 1'b0;   // fix stage takes the result at this edge
  end

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      req.start        <= 1'b0;
      req.dividend_mag <= '0;
      req.divisor_mag  <= '0;
      req.neg_quot     <= 1'b0;
      req.neg_rem      <= 1'b0;
      req.zero_div     <= 1'b0;
    end
    else
    begin
      req.start <= accept;  // single-cycle strobe
      // held until the next accepted request, fix reads the flags late
      if (accept)
      begin
        req.dividend_mag <= a_abs;
        req.divisor_mag  <= b_abs;
        req.neg_quot     <= (a_neg ^ b_neg) && !b_zero;
        req.neg_rem      <= a_neg;
        req.zero_div     <= b_zero;
      end
    end
  end

endmodule

`default_nettype wire

// File: restoring_divider.sv
// iterative restoring divider, unsigned magnitudes
// one quotient bit per cycle, WIDTH iterations plus one result edge

`timescale 1ns/1ps
`default_nettype none

module restoring_divider #(
  parameter int WIDTH = div_data_pkg::DIV_WIDTH
)
(
  input  logic    CLK,
  input  logic    CLR,
  div_core_if.dst req,
  div_core_if.src res
);

  localparam int CNT_W = $clog2(WIDTH);

  div_ctrl_pkg::core_state_t state;

  logic [2*WIDTH-1:0] part_rem;  // upper half remainder, lower half dividend bits left
  logic [WIDTH-1:0]   quot;
  logic [CNT_W-1:0]   bit_cnt;   // iterations still to go after this one
  logic [WIDTH+1:0]   diff;
  logic               borrow;

  // trial subtraction on the remainder shifted left with the next dividend bit
  assign diff   = {1'b0, part_rem[2*WIDTH-1:WIDTH-1]} - {2'b00, req.divisor_mag};
  assign borrow = diff[WIDTH+1];

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      state        <= div_ctrl_pkg::ST_IDLE;
      part_rem     <= '0;
      quot         <= '0;
      bit_cnt      <= '0;
      res.done     <= 1'b0;
      res.quot_mag <= '0;
      res.rem_mag  <= '0;
    end
    else
    begin
      res.done <= 1'b0;
      case (state)
        div_ctrl_pkg::ST_IDLE:
        begin
          if (req.start)
          begin
            part_rem <= {{WIDTH{1'b0}}, req.dividend_mag};
            quot     <= '0;
            bit_cnt  <= CNT_W'(WIDTH - 1);
            state    <= div_ctrl_pkg::ST_RUN;
          end
        end

        div_ctrl_pkg::ST_RUN:
        begin
          if (!borrow)
            part_rem <= {diff[WIDTH-1:0], part_rem[WIDTH-2:0], 1'b0};  // keep difference
          else
            part_rem <= part_rem << 1;  // restore, just shift
          quot <= {quot[WIDTH-2:0], ~borrow};
          if (bit_cnt == '0)
            state <= div_ctrl_pkg::ST_DONE;
          else
            bit_cnt <= bit_cnt - 1'b1;
        end

        div_ctrl_pkg::ST_DONE:
        begin
          // zero divisor never borrows: all-ones quotient, dividend as remainder
          res.quot_mag <= quot;
          res.rem_mag  <= part_rem[2*WIDTH-1:WIDTH];
          res.done     <= 1'b1;
          state        <= div_ctrl_pkg::ST_IDLE;
        end

        default:
          state <= div_ctrl_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: div_result_fix.sv
// sign restore and divide-by-zero handling of the core result
// registers the unit outputs and the out_valid strobe

`timescale 1ns/1ps
`default_nettype none

module div_result_fix #(
  parameter int WIDTH = div_data_pkg::DIV_WIDTH
)
(
  input  logic             CLK,
  input  logic             CLR,
  div_core_if.dst          res,
  div_core_if.mon          req,
  output logic             out_valid,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             div_by_zero
);

  logic [WIDTH-1:0] q_signed;
  logic [WIDTH-1:0] q_final;
  logic [WIDTH-1:0] r_final;

  assign q_signed = req.neg_quot ? (~res.quot_mag + 1'b1) : res.quot_mag;

  // all ones reads as -1 in signed mode
  assign q_final = req.zero_div ? {WIDTH{1'b1}} : q_signed;

  // remainder follows the dividend sign
  assign r_final = req.neg_rem ? (~res.rem_mag + 1'b1) : res.rem_mag;

  always_ff @(posedge CLK or posedge CLR)
  begin
    if (CLR)
    begin
      out_valid   <= 1'b0;
      quotient    <= '0;
      remainder   <= '0;
      div_by_zero <= 1'b0;
    end
    else
    begin
      out_valid <= res.done;  // one cycle after done
      if (res.done)
      begin
        quotient    <= q_final;
        remainder   <= r_final;
        div_by_zero <= req.zero_div;
      end
    end
  end

endmodule

`default_nettype wire

// File: div_unit_top.sv
// top level of the 16-bit division unit
// operand prep, restoring core and result fix joined by two buses

`timescale 1ns/1ps
`default_nettype none

module div_unit_top #(
  parameter int WIDTH = div_data_pkg::DIV_WIDTH
)
(
  input  logic             CLK,
  input  logic             CLR,
  input  logic             in_valid,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic             busy,
  output logic             out_valid,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             div_by_zero
);

  // prep to core, flags ride along for the fix stage
  div_core_if #(.WIDTH(WIDTH)) req_bus ();

  // core to fix
  div_core_if #(.WIDTH(WIDTH)) res_bus ();

  div_operand_prep #(
    .WIDTH (WIDTH)
  ) u_prep (
    .CLK       (CLK),
    .CLR       (CLR),
    .in_valid  (in_valid),
    .is_signed (is_signed),
    .dividend  (dividend),
    .divisor   (divisor),
    .busy      (busy),
    .req       (req_bus.src),
    .res       (res_bus.mon)   // done clears busy
  );

  restoring_divider #(
    .WIDTH (WIDTH)
  ) u_core (
    .CLK (CLK),
    .CLR (CLR),
    .req (req_bus.dst),
    .res (res_bus.src)
  );

  div_result_fix #(
    .WIDTH (WIDTH)
  ) u_fix (
    .CLK         (CLK),
    .CLR         (CLR),
    .res         (res_bus.dst),
    .req         (req_bus.mon),
    .out_valid   (out_valid),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero)
  );

endmodule

`default_nettype wire

// File: div_unit_checker.sv
// concurrent assertions for the division unit
// strobe width, busy tracking and divide-by-zero result

`timescale 1ns/1ps
`default_nettype none

module div_unit_checker #(
  parameter int WIDTH = div_data_pkg::DIV_WIDTH
)
(
  input logic                      CLK,
  input logic                      CLR,
  input logic                      in_valid,
  input logic                      busy,
  input logic                      out_valid,
  input logic [WIDTH-1:0]          quotient,
  input logic                      div_by_zero,
  input div_ctrl_pkg::core_state_t core_state
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  a_out_pulse: assert property (@(posedge CLK) disable iff (CLR)
    out_valid |=> !out_valid)
  else
  begin
    $error("out_valid high for more than one cycle");
    fail_cnt++;
  end

  // accepted request sets busy at the same edge
  a_accept_busy: assert property (@(posedge CLK) disable iff (CLR)
    (in_valid && !busy) |=> busy)
  else
  begin
    $error("busy did not rise after an accepted request");
    fail_cnt++;
  end

  a_core_busy: assert property (@(posedge CLK) disable iff (CLR)
    (core_state != div_ctrl_pkg::ST_IDLE) |-> busy)
  else
  begin
    $error("core running while busy is low");
    fail_cnt++;
  end

  a_out_not_busy: assert property (@(posedge CLK) disable iff (CLR)
    out_valid |-> !busy)  // busy drops as the result leaves
  else
  begin
    $error("busy still high while out_valid is high");
    fail_cnt++;
  end

  a_zero_quot: assert property (@(posedge CLK) disable iff (CLR)
    (out_valid && div_by_zero) |-> (quotient == {WIDTH{1'b1}}))
  else
  begin
    $error("divide by zero without an all-ones quotient");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: tb_div_unit.sv
// testbench for the division unit with reference model and result queue
// directed, xorshift random, back-to-back and busy drop stimulus

`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

  localparam int W           = div_data_pkg::DIV_WIDTH;
  localparam int N_DIRECTED  = 40;   // upper bound of directed, corner and burst requests
  localparam int N_URAND     = 200;
  localparam int N_SRAND     = 25;   // per sign combination
  localparam int WDOG_CYCLES = (N_DIRECTED + N_URAND + 4 * N_SRAND) * 25 + 500;

  // one expected result, pushed when the DUT accepts a request
  typedef struct packed {
    div_data_pkg::word_t q;
    div_data_pkg::word_t r;
    logic                z;
    div_data_pkg::word_t divisor;
    logic                sgn;
    logic [31:0]         acc_edge;
  } expect_t;

  logic                CLK = 1'b0;
  logic                CLR;
  logic                in_valid;
  logic                is_signed;
  div_data_pkg::word_t dividend;
  div_data_pkg::word_t divisor;
  logic                busy;
  logic                out_valid;
  div_data_pkg::word_t quotient;
  div_data_pkg::word_t remainder;
  logic                div_by_zero;

  expect_t     pend_q[$];
  logic [31:0] rng = 32'h6185;
  int unsigned cycle = 0;      // rising edges so far
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned n_accept = 0;
  int unsigned n_result = 0;
  int unsigned n_dropped = 0;
  int unsigned n_tests = 0;
  int unsigned test_err0;
  int unsigned test_chk0;
  string       cur_test = "reset";

  always #5 CLK = ~CLK;

  always @(posedge CLK)
    cycle <= cycle + 1;

  div_unit_top #(
    .WIDTH (W)
  ) DUT (
    .CLK         (CLK),
    .CLR         (CLR),
    .in_valid    (in_valid),
    .is_signed   (is_signed),
    .dividend    (dividend),
    .divisor     (divisor),
    .busy        (busy),
    .out_valid   (out_valid),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero)
  );

  bind div_unit_top div_unit_checker #(
    .WIDTH (WIDTH)
  ) u_checker (
    .CLK         (CLK),
    .CLR         (CLR),
    .in_valid    (in_valid),
    .busy        (busy),
    .out_valid   (out_valid),
    .quotient    (quotient),
    .div_by_zero (div_by_zero),
    .core_state  (u_core.state)
  );

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // truncating division, remainder with dividend sign, x/0 gives -1 rem x
  function automatic expect_t model_div(input div_data_pkg::word_t a,
                                        input div_data_pkg::word_t b, input logic sgn);
    div_data_pkg::wide_t wa;
    div_data_pkg::wide_t wb;
    div_data_pkg::wide_t wq;
    div_data_pkg::wide_t wr;
    expect_t             e;
    e         = '0;
    e.divisor = b;
    e.sgn     = sgn;
    wa = sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
    wb = sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
    if (b == '0)
    begin
      e.q = '1;
      e.r = a;
      e.z = 1'b1;
    end
    else
    begin
      wq  = wa / wb;
      wr  = wa % wb;
      e.q = wq[W-1:0];  // most negative / -1 wraps back to itself
      e.r = wr[W-1:0];
    end
    return e;
  endfunction

  task automatic check_result(input expect_t e);
    checks += 4;
    assert (quotient == e.q)
    else
    begin
      $display("[FAIL] %s quotient expected %h actual %h", cur_test, e.q, quotient);
      errors++;
    end
    assert (remainder == e.r)
    else
    begin
      $display("[FAIL] %s remainder expected %h actual %h", cur_test, e.r, remainder);
      errors++;
    end
    assert (div_by_zero == e.z)
    else
    begin
      $display("[FAIL] %s div_by_zero expected %b actual %b", cur_test, e.z, div_by_zero);
      errors++;
    end
    assert (cycle - e.acc_edge == 19)
    else
    begin
      $display("[FAIL] %s latency expected 19 actual %0d", cur_test, cycle - e.acc_edge);
      errors++;
    end
    if (!e.sgn && !e.z)
    begin
      checks++;
      assert (remainder < e.divisor)
      else
      begin
        $display("[FAIL] %s remainder expected below %h actual %h", cur_test, e.divisor,
                 remainder);
        errors++;
      end
    end
  endtask

  // outputs and handshake sampled mid-cycle
  always @(negedge CLK)
  begin
    expect_t e;
    if (!CLR)
    begin
      if (out_valid)
      begin
        n_result++;
        if (pend_q.size() == 0)
        begin
          $display("error in %s: out_valid without an accepted request", cur_test);
          errors++;
        end
        else
        begin
          e = pend_q.pop_front();
          check_result(e);
        end
      end
      if (in_valid && busy)
        n_dropped++;
      else if (in_valid)
      begin
        e          = model_div(dividend, divisor, is_signed);
        e.acc_edge = cycle + 1;  // taken at the coming edge
        pend_q.push_back(e);
        n_accept++;
      end
    end
  end

  // returns at the edge that samples the request
  task automatic send(input div_data_pkg::word_t a, input div_data_pkg::word_t b,
                      input logic sgn);
    @(posedge CLK);
    in_valid  <= 1'b1;
    is_signed <= sgn;
    dividend  <= a;
    divisor   <= b;
    @(posedge CLK);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge CLK);
    while ((pend_q.size() != 0 || busy) && n < 40)
    begin
      @(negedge CLK);
      n++;
    end
    if (pend_q.size() != 0 || busy)
    begin
      $display("error in %s: result did not arrive within 40 cycles", cur_test);
      errors++;
      pend_q.delete();
    end
  endtask

  task automatic run_one(input div_data_pkg::word_t a, input div_data_pkg::word_t b,
                         input logic sgn);
    send(a, b, sgn);
    wait_drain();
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
    test_chk0 = checks;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %-18s %0d checks, %0d errors", cur_test, checks - test_chk0,
             errors - test_err0);
  endtask

  initial
  begin
    int                  i;
    int                  k;
    int unsigned         acc0;
    int unsigned         drop0;
    div_data_pkg::word_t a;
    div_data_pkg::word_t b;
    CLR       = 1'b1;
    in_valid  = 1'b0;
    is_signed = 1'b0;
    dividend  = '0;
    divisor   = '0;
    repeat (4) @(posedge CLK);
    CLR <= 1'b0;
    @(negedge CLK);

    start_test("reset");
    checks += 2;
    assert (busy == 1'b0)
    else
    begin
      $display("[FAIL] reset busy expected 0 actual %b", busy);
      errors++;
    end
    assert (out_valid == 1'b0)
    else
    begin
      $display("[FAIL] reset out_valid expected 0 actual %b", out_valid);
      errors++;
    end
    end_test();

    start_test("unsigned_directed");
    run_one(16'd100, 16'd7, 1'b0);
    run_one(16'd0, 16'd5, 1'b0);
    run_one(16'd5, 16'd5, 1'b0);
    run_one(16'd4, 16'd5, 1'b0);
    run_one(16'hffff, 16'd1, 1'b0);
    run_one(16'hffff, 16'hffff, 1'b0);
    run_one(16'hffff, 16'd2, 1'b0);
    run_one(16'h8000, 16'd3, 1'b0);
    run_one(16'd1, 16'hffff, 1'b0);
    run_one(16'd12345, 16'd123, 1'b0);
    end_test();

    start_test("unsigned_random");
    for (i = 0; i < N_URAND; i++)
    begin
      rng = next_rand(rng);
      a   = rng[W-1:0];
      rng = next_rand(rng);
      b   = rng[W-1:0] >> rng[W+3:W];  // spread of divisor sizes
      if (b == '0)
        b = 16'd1;
      run_one(a, b, 1'b0);
    end
    end_test();

    start_test("signed_random");
    for (k = 0; k < 4; k++)
    begin
      for (i = 0; i < N_SRAND; i++)
      begin
        rng = next_rand(rng);
        a   = {k[1], rng[W-2:0]};
        rng = next_rand(rng);
        b   = {1'b0, rng[W-2:0]} >> rng[W+3:W];
        if (b == '0)
          b = 16'd1;
        if (k[0])
          b = -b;
        run_one(a, b, 1'b1);
      end
    end
    end_test();

    start_test("signed_corner");
    run_one(16'h8000, 16'hffff, 1'b1);  // overflow case
    run_one(16'h8000, 16'd1, 1'b1);
    run_one(16'h8000, 16'h8000, 1'b1);
    run_one(16'd7, 16'hfffe, 1'b1);
    run_one(16'hfff9, 16'd2, 1'b1);
    run_one(16'hfff9, 16'hfffe, 1'b1);
    run_one(16'h7fff, 16'h8000, 1'b1);
    run_one(16'hffff, 16'h8000, 1'b1);
    end_test();

    start_test("div_by_zero");
    run_one(16'd1234, 16'd0, 1'b0);
    run_one(16'd0, 16'd0, 1'b0);
    run_one(16'hffff, 16'd0, 1'b0);
    run_one(16'hfffb, 16'd0, 1'b1);
    run_one(16'h8000, 16'd0, 1'b1);
    run_one(16'd7, 16'd0, 1'b1);
    end_test();

    // next request lands on the edge where busy has just dropped
    start_test("back_to_back");
    send(16'd40000, 16'd9, 1'b0);
    for (i = 0; i < 5; i++)
    begin
      repeat (18) @(posedge CLK);
      rng = next_rand(rng);
      send(rng[W-1:0], {1'b0, rng[W+7:W]} + 16'd1, rng[31]);
    end
    wait_drain();
    end_test();

    start_test("busy_drop");
    acc0  = n_accept;
    drop0 = n_dropped;
    send(16'd5000, 16'd3, 1'b0);
    @(posedge CLK);
    in_valid <= 1'b1;
    dividend <= 16'd77;
    divisor  <= 16'd0;
    repeat (10) @(posedge CLK);
    in_valid <= 1'b0;
    wait_drain();
    repeat (30) @(negedge CLK);  // room for a stray out_valid
    checks += 3;
    assert (n_dropped - drop0 == 10)
    else
    begin
      $display("[FAIL] busy_drop dropped expected 10 actual %0d", n_dropped - drop0);
      errors++;
    end
    assert (n_accept - acc0 == 1)
    else
    begin
      $display("[FAIL] busy_drop accepted expected 1 actual %0d", n_accept - acc0);
      errors++;
    end
    assert (n_result == n_accept)
    else
    begin
      $display("[FAIL] busy_drop results expected %0d actual %0d", n_accept, n_result);
      errors++;
    end
    end_test();

    $display("total: %0d tests, %0d checks, %0d errors, %0d assertion failures", n_tests,
             checks, errors, DUT.u_checker.fail_cnt);
    if (errors == 0 && DUT.u_checker.fail_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    repeat (WDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
div_data_pkg.sv
div_ctrl_pkg.sv
div_core_if.sv
div_operand_prep.sv
restoring_divider.sv
div_result_fix.sv
div_unit_top.sv
div_unit_checker.sv
tb_div_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the division unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_div_unit -f build.f > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_div_unit +verilator+error+limit+1000 > "$LOG" 2>&1 \
  || echo "simulator returned a failing status"

cat "$LOG"

grep -qx "Simulation passed" "$LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
